// File: platform_defs.svh
// Shared constants for the arcade platform shell
// Colour and audio widths, the PS/2 frame length and the scancodes that the
// keyboard decoder recognises. Include this file wherever one of the macros
// is needed; the guard makes repeated includes harmless.

`ifndef PLATFORM_DEFS_SVH
`define PLATFORM_DEFS_SVH

// Colour channel widths from the game core and towards the VGA connector
`define PLAT_COLOR_IN_W  3
`define PLAT_COLOR_OUT_W 6

`define PLAT_AUDIO_W 10

// Start bit, 8 data bits, odd parity and stop bit
`define PS2_FRAME_BITS 11

// ========================================
// Scancodes, set 2
// ========================================
`define SC_BREAK  8'hF0
`define SC_EXT    8'hE0
`define SC_COIN   8'h2E
`define SC_START1 8'h16
`define SC_START2 8'h1E
`define SC_FIRE   8'h29
`define SC_UP     8'h75
`define SC_DOWN   8'h72
`define SC_LEFT   8'h6B
`define SC_RIGHT  8'h74

`endif

// File: ps2_pkg.sv
// Keyboard side types of the arcade platform
// The received PS/2 byte and the set of cabinet keys that the scancode
// decoder tracks. The key state vector is indexed by the key enumeration.

package ps2_pkg;

	typedef logic [7:0] ps2_byte_t;

	// One entry per cabinet control that a key can drive
	typedef enum logic [2:0] {
		KEY_UP     = 3'd0,
		KEY_DOWN   = 3'd1,
		KEY_LEFT   = 3'd2,
		KEY_RIGHT  = 3'd3,
		KEY_FIRE   = 3'd4,
		KEY_START1 = 3'd5,
		KEY_START2 = 3'd6,
		KEY_COIN   = 3'd7
	} cab_key_e;

	// A set bit means the key is held down
	typedef logic [7:0] key_state_t;

endpackage

// File: platform_pkg.sv
// Platform side types of the arcade platform
// Cabinet controls as seen by the game core, the video bundle coming out of
// the core, the video bundle going to the VGA connector and the scanline
// effect modes.

`include "platform_defs.svh"

package platform_pkg;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} controls_t;

	// Raw video as produced by the game core, one pixel per ce_pix
	typedef struct packed {
		logic [`PLAT_COLOR_IN_W-1:0] r;
		logic [`PLAT_COLOR_IN_W-1:0] g;
		logic [`PLAT_COLOR_IN_W-1:0] b;
		logic                        hs;
		logic                        vs;
		logic                        hblank;
		logic                        vblank;
	} core_video_t;

	typedef struct packed {
		logic [`PLAT_COLOR_OUT_W-1:0] r;
		logic [`PLAT_COLOR_OUT_W-1:0] g;
		logic [`PLAT_COLOR_OUT_W-1:0] b;
		logic                         hs;
		logic                         vs;
	} vga_video_t;

	// How much of the brightness is taken away on darkened lines
	typedef enum logic [1:0] {
		SL_NONE  = 2'd0,
		SL_PCT25 = 2'd1,
		SL_PCT50 = 2'd2,
		SL_PCT75 = 2'd3
	} scanline_e;

endpackage

// File: ps2_receiver.sv
// PS/2 keyboard receiver
// Brings the keyboard clock and data into the clk_sys domain, shifts in one
// frame per byte and hands out the data byte with a one-cycle rx_valid when
// start, parity and stop bits are all correct. Broken frames are dropped.

`timescale 1ns/1ps
`include "platform_defs.svh"

module ps2_receiver (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	output ps2_pkg::ps2_byte_t  rx_byte,
	output logic                rx_valid
);

	localparam int IDLE_LIMIT = 4095;

	logic [1:0]  clk_sync;
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        fall;
	logic [3:0]  bit_cnt;
	// Holds start, data and parity, newest bit at the top
	logic [9:0]  shift;
	logic [11:0] idle_cnt;
	logic        frame_ok;

	assign frame_ok = ~shift[0] & (^shift[9:1]) & data_sync[1];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
			fall      <= 1'b0;
			bit_cnt   <= '0;
			idle_cnt  <= '0;
			rx_valid  <= 1'b0;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
			fall      <= clk_prev & ~clk_sync[1];
			rx_valid  <= 1'b0;

			// A stalled partial frame is abandoned after a long idle high
			if (!clk_sync[1] || bit_cnt == '0 || fall)
				idle_cnt <= '0;
			else if (idle_cnt == IDLE_LIMIT[11:0]) begin
				idle_cnt <= '0;
				bit_cnt  <= '0;
			end else
				idle_cnt <= idle_cnt + 12'd1;

			if (fall) begin
				if (bit_cnt == 4'(`PS2_FRAME_BITS - 1)) begin
					bit_cnt  <= '0;
					rx_valid <= frame_ok;
				end else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fall && bit_cnt != 4'(`PS2_FRAME_BITS - 1))
			shift <= {data_sync[1], shift[9:1]};
		if (fall && bit_cnt == 4'(`PS2_FRAME_BITS - 1))
			rx_byte <= shift[8:1];
	end

endmodule

// File: kbd_decoder.sv
// Scancode decoder for the cabinet keys
// Follows the break (F0) and extended (E0) prefixes of scancode set 2 and
// keeps one pressed bit per cabinet key. Codes that belong to no cabinet key
// are ignored, and arrow codes only count behind an extended prefix.

`timescale 1ns/1ps
`include "platform_defs.svh"

module kbd_decoder (
	input  logic                clk_sys,
	input  logic                rst,
	input  ps2_pkg::ps2_byte_t  rx_byte,
	input  logic                rx_valid,
	output ps2_pkg::key_state_t keys
);

	import ps2_pkg::*;

	logic     brk;
	logic     ext;
	logic     hit;
	cab_key_e key;

	// Map the current byte onto a cabinet key
	always_comb begin
		hit = 1'b1;
		key = KEY_UP;
		if (ext) begin
			case (rx_byte)
				`SC_UP:    key = KEY_UP;
				`SC_DOWN:  key = KEY_DOWN;
				`SC_LEFT:  key = KEY_LEFT;
				`SC_RIGHT: key = KEY_RIGHT;
				default:   hit = 1'b0;
			endcase
		end else begin
			case (rx_byte)
				`SC_FIRE:   key = KEY_FIRE;
				`SC_START1: key = KEY_START1;
				`SC_START2: key = KEY_START2;
				`SC_COIN:   key = KEY_COIN;
				default:    hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			brk  <= 1'b0;
			ext  <= 1'b0;
			keys <= '0;
		end else if (rx_valid) begin
			if (rx_byte == `SC_BREAK)
				brk <= 1'b1;
			else if (rx_byte == `SC_EXT)
				ext <= 1'b1;
			else begin
				// Both prefixes are spent on the first ordinary byte
				brk <= 1'b0;
				ext <= 1'b0;
				if (hit)
					keys[key] <= ~brk;
			end
		end
	end

endmodule

// File: control_mapper.sv
// Cabinet control mapper
// Merges the keyboard keys with two digital joysticks and swaps the
// directions when the screen is rotated. Joystick bits 0 to 4 are right,
// left, down, up and fire. The result is registered once.

`timescale 1ns/1ps

module control_mapper (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  ps2_pkg::key_state_t   keys,
	input  logic [7:0]            joy0,
	input  logic [7:0]            joy1,
	input  logic                  rotate,
	output platform_pkg::controls_t controls
);

	import ps2_pkg::*;

	logic src_up, src_down, src_left, src_right, src_fire;

	assign src_right = keys[KEY_RIGHT] | joy0[0] | joy1[0];
	assign src_left  = keys[KEY_LEFT]  | joy0[1] | joy1[1];
	assign src_down  = keys[KEY_DOWN]  | joy0[2] | joy1[2];
	assign src_up    = keys[KEY_UP]    | joy0[3] | joy1[3];
	assign src_fire  = keys[KEY_FIRE]  | joy0[4] | joy1[4];

	always_ff @(posedge clk_sys) begin
		if (rst)
			controls <= '0;
		else begin
			// A rotated screen turns the stick a quarter turn
			controls.up     <= rotate ? src_left  : src_up;
			controls.down   <= rotate ? src_right : src_down;
			controls.left   <= rotate ? src_down  : src_left;
			controls.right  <= rotate ? src_up    : src_right;
			controls.fire   <= src_fire;
			controls.start1 <= keys[KEY_START1];
			controls.start2 <= keys[KEY_START2];
			controls.coin   <= keys[KEY_COIN];
		end
	end

endmodule

// File: video_front.sv
// Video front end, first pixel stage
// Registers the core video on ce_pix and forces the colour to black during
// blanking. A line parity that toggles on each rising hsync and clears in
// vsync decides which lines get the scanline darkening.

`timescale 1ns/1ps
`include "platform_defs.svh"

module video_front (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    ce_pix,
	input  platform_pkg::core_video_t core_video,
	input  platform_pkg::scanline_e scanlines,
	output logic [2:0][`PLAT_COLOR_IN_W-1:0] chan_in,
	output platform_pkg::scanline_e darken,
	output logic                    hs_d,
	output logic                    vs_d
);

	import platform_pkg::*;

	logic blank;
	logic line_odd;

	assign blank = core_video.hblank | core_video.vblank;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			chan_in  <= '0;
			darken   <= SL_NONE;
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			line_odd <= 1'b0;
		end else if (ce_pix) begin
			hs_d <= core_video.hs;
			vs_d <= core_video.vs;

			if (core_video.vs)
				line_odd <= 1'b0;
			else if (core_video.hs && !hs_d)
				line_odd <= ~line_odd;

			// Channel order is red, green, blue
			chan_in[0] <= blank ? '0 : core_video.r;
			chan_in[1] <= blank ? '0 : core_video.g;
			chan_in[2] <= blank ? '0 : core_video.b;
			darken     <= line_odd ? scanlines : SL_NONE;
		end
	end

endmodule

// File: color_channel.sv
// One colour channel of the video path, second pixel stage
// Widens the core colour by bit replication and applies the scanline
// darkening chosen for the current line. One instance per red, green, blue.

`timescale 1ns/1ps
`include "platform_defs.svh"

module color_channel (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic                          ce_pix,
	input  logic [`PLAT_COLOR_IN_W-1:0]   chan,
	input  platform_pkg::scanline_e       darken,
	output logic [`PLAT_COLOR_OUT_W-1:0]  level
);

	import platform_pkg::*;

	logic [`PLAT_COLOR_OUT_W-1:0] wide;
	logic [`PLAT_COLOR_OUT_W-1:0] dimmed;

	// Writing the value twice maps full scale onto full scale
	assign wide = {chan, chan};

	always_comb begin
		case (darken)
			SL_PCT25: dimmed = wide - (wide >> 2);
			SL_PCT50: dimmed = wide >> 1;
			SL_PCT75: dimmed = wide >> 2;
			default:  dimmed = wide;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			level <= '0;
		else if (ce_pix)
			level <= dimmed;
	end

endmodule

// File: vga_out.sv
// VGA output register, last pixel stage
// Collects the three channel levels into the VGA bundle. The syncs take one
// extra stage here so they line up with the colour channel registers.

`timescale 1ns/1ps
`include "platform_defs.svh"

module vga_out (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  logic                                 ce_pix,
	input  logic [2:0][`PLAT_COLOR_OUT_W-1:0]    levels,
	input  logic                                 hs_in,
	input  logic                                 vs_in,
	output platform_pkg::vga_video_t             vga
);

	logic hs_q;
	logic vs_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			vga  <= '0;
		end else if (ce_pix) begin
			hs_q  <= hs_in;
			vs_q  <= vs_in;
			vga.r <= levels[0];
			vga.g <= levels[1];
			vga.b <= levels[2];
			vga.hs <= hs_q;
			vga.vs <= vs_q;
		end
	end

endmodule

// File: sigma_delta_dac.sv
// First-order sigma-delta audio DAC
// Adds the sample into an accumulator every clk_sys cycle; the carry out of
// the low bits is the one-bit audio pin. Over 1024 cycles with a steady
// sample the pin is high exactly sample times. Feed the pin through an RC
// low-pass on the board.

`timescale 1ns/1ps
`include "platform_defs.svh"

module sigma_delta_dac (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic [`PLAT_AUDIO_W-1:0] sample,
	output logic                     audio
);

	// Top bit is the carry of the last addition
	logic [`PLAT_AUDIO_W:0] acc;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc   <= '0;
			audio <= 1'b0;
		end else begin
			acc   <= {1'b0, acc[`PLAT_AUDIO_W-1:0]} + {1'b0, sample};
			audio <= acc[`PLAT_AUDIO_W];
		end
	end

endmodule

// File: arcade_platform.sv
// Platform shell around an arcade game core
// Keyboard and joysticks become cabinet controls for the core, the core's
// video goes out as 6-bit VGA with optional scanlines, and its audio sample
// drives a one-bit sigma-delta pin. All logic runs on clk_sys; the video
// stages advance on ce_pix.

`timescale 1ns/1ps
`include "platform_defs.svh"

module arcade_platform (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      ps2_clk,
	input  logic                      ps2_data,
	input  logic [7:0]                joy0,
	input  logic [7:0]                joy1,
	input  logic                      rotate,
	input  platform_pkg::scanline_e   scanlines,
	input  logic                      ce_pix,
	input  platform_pkg::core_video_t core_video,
	input  logic [`PLAT_AUDIO_W-1:0]  sample,
	output platform_pkg::controls_t   controls,
	output platform_pkg::vga_video_t  vga,
	output logic                      audio
);

	import ps2_pkg::*;
	import platform_pkg::*;

	ps2_byte_t  rx_byte;
	logic       rx_valid;
	key_state_t keys;

	logic [2:0][`PLAT_COLOR_IN_W-1:0]  chan_in;
	logic [2:0][`PLAT_COLOR_OUT_W-1:0] levels;
	scanline_e                         darken;
	logic                              hs_d;
	logic                              vs_d;

	// ========================================
	// Input path
	// ========================================
	ps2_receiver u_ps2_receiver (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	kbd_decoder u_kbd_decoder (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.keys     (keys)
	);

	control_mapper u_control_mapper (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.keys     (keys),
		.joy0     (joy0),
		.joy1     (joy1),
		.rotate   (rotate),
		.controls (controls)
	);

	// ========================================
	// Video path
	// ========================================
	video_front u_video_front (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce_pix     (ce_pix),
		.core_video (core_video),
		.scanlines  (scanlines),
		.chan_in    (chan_in),
		.darken     (darken),
		.hs_d       (hs_d),
		.vs_d       (vs_d)
	);

	// Index 0 is red, 1 green, 2 blue
	for (genvar i = 0; i < 3; i++) begin : g_chan
		color_channel u_color_channel (
			.clk_sys (clk_sys),
			.rst     (rst),
			.ce_pix  (ce_pix),
			.chan    (chan_in[i]),
			.darken  (darken),
			.level   (levels[i])
		);
	end

	vga_out u_vga_out (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_pix  (ce_pix),
		.levels  (levels),
		.hs_in   (hs_d),
		.vs_in   (vs_d),
		.vga     (vga)
	);

	// ========================================
	// Audio path
	// ========================================
	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (sample),
		.audio   (audio)
	);

endmodule

// File: tb_arcade_platform.sv
// Directed testbench for the arcade platform shell
// Plays the part of the keyboard, the joysticks and the game core. It checks
// the cabinet controls, the VGA pixel pipeline with blanking and scanlines,
// and the one-bit audio density. The first mismatch ends the run.

`timescale 1ns/1ps
`include "platform_defs.svh"

module tb_arcade_platform;

	import platform_pkg::*;

	// Key masks in controls_t bit order
	localparam logic [7:0] mask_up     = 8'h80;
	localparam logic [7:0] mask_down   = 8'h40;
	localparam logic [7:0] mask_left   = 8'h20;
	localparam logic [7:0] mask_right  = 8'h10;
	localparam logic [7:0] mask_fire   = 8'h08;
	localparam logic [7:0] mask_start1 = 8'h04;
	localparam logic [7:0] mask_start2 = 8'h02;
	localparam logic [7:0] mask_coin   = 8'h01;

	logic                     clk_sys = 1'b0;
	logic                     rst;
	logic                     ps2_clk;
	logic                     ps2_data;
	logic [7:0]               joy0;
	logic [7:0]               joy1;
	logic                     rotate;
	scanline_e                scanlines;
	logic                     ce_pix;
	core_video_t              core_video;
	logic [`PLAT_AUDIO_W-1:0] sample;
	controls_t                controls;
	vga_video_t               vga;
	logic                     audio;

	// Keys that the testbench currently holds down
	controls_t   kb_model;
	logic [31:0] lfsr_state;

	arcade_platform u_arcade_platform (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.joy0       (joy0),
		.joy1       (joy1),
		.rotate     (rotate),
		.scanlines  (scanlines),
		.ce_pix     (ce_pix),
		.core_video (core_video),
		.sample     (sample),
		.controls   (controls),
		.vga        (vga),
		.audio      (audio)
	);

	initial begin
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================

	// Galois LFSR that steps once per bit handed out
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000)
				: (lfsr_state >> 1);
		end
		return r;
	endfunction

	function automatic controls_t expected_controls(input controls_t kb, input logic [7:0] j0,
			input logic [7:0] j1, input logic rot);
		controls_t c;
		logic      dir_up;
		logic      dir_down;
		logic      dir_left;
		logic      dir_right;
		dir_right = kb.right | j0[0] | j1[0];
		dir_left  = kb.left  | j0[1] | j1[1];
		dir_down  = kb.down  | j0[2] | j1[2];
		dir_up    = kb.up    | j0[3] | j1[3];
		// Start and coin are keyboard only
		c = kb;
		c.fire  = kb.fire | j0[4] | j1[4];
		c.up    = rot ? dir_left  : dir_up;
		c.down  = rot ? dir_right : dir_down;
		c.left  = rot ? dir_down  : dir_left;
		c.right = rot ? dir_up    : dir_right;
		return c;
	endfunction

	function automatic logic [5:0] scanline_level(input logic [2:0] c, input scanline_e mode);
		int v;
		// Writing a 3-bit value twice is the same as multiplying it by 9
		v = c * 9;
		case (mode)
			SL_PCT25: v = v - v / 4;
			SL_PCT50: v = v / 2;
			SL_PCT75: v = v / 4;
			default: ;
		endcase
		return 6'(v);
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s, expected %0h, got %0h",
				$time, what, expected, actual);
			$display("Regression failed");
			$fatal(1, "Stopping at the first error");
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		rst = 1'b1;
		repeat (3) @(negedge clk_sys);
		rst = 1'b0;
	endtask

	// Sends one PS/2 frame LSB first with the keyboard clock toggling every 20 cycles
	task automatic send_frame(input logic [7:0] data, input bit flip_parity);
		logic [10:0] bits;
		bits = {1'b1, ~(^data) ^ flip_parity, data, 1'b0};
		for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
			@(negedge clk_sys);
			ps2_data = bits[i];
			repeat (20) @(negedge clk_sys);
			ps2_clk = 1'b0;
			repeat (20) @(negedge clk_sys);
			ps2_clk = 1'b1;
		end
		repeat (20) @(negedge clk_sys);
	endtask

	task automatic wait_controls(input string what);
		controls_t exp;
		bit        seen;
		exp  = expected_controls(kb_model, joy0, joy1, rotate);
		seen = 1'b0;
		for (int i = 0; i < 200 && !seen; i++) begin
			@(negedge clk_sys);
			if (controls == exp)
				seen = 1'b1;
		end
		if (!seen)
			$display("Timeout: the controls never reached the expected value for %s", what);
		check_value(32'(controls), 32'(exp), what);
	endtask

	task automatic key_action(input logic [7:0] code, input bit ext, input bit brk,
			input logic [7:0] mask, input string what);
		if (ext)
			send_frame(`SC_EXT, 1'b0);
		if (brk)
			send_frame(`SC_BREAK, 1'b0);
		send_frame(code, 1'b0);
		kb_model = brk ? (kb_model & ~mask) : (kb_model | mask);
		wait_controls(what);
	endtask

	task automatic drive_stick(input logic [7:0] j0, input logic [7:0] j1, input logic rot,
			input string what);
		@(negedge clk_sys);
		joy0   = j0;
		joy1   = j1;
		rotate = rot;
		wait_controls(what);
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic coin_start_keys();
		key_action(`SC_COIN, 1'b0, 1'b0, mask_coin, "coin make");
		key_action(`SC_COIN, 1'b0, 1'b1, mask_coin, "coin break");
		key_action(`SC_START1, 1'b0, 1'b0, mask_start1, "start1 make");
		key_action(`SC_START1, 1'b0, 1'b1, mask_start1, "start1 break");
		key_action(`SC_START2, 1'b0, 1'b0, mask_start2, "start2 make");
		key_action(`SC_START2, 1'b0, 1'b1, mask_start2, "start2 break");
	endtask

	task automatic arrows_and_rotation();
		key_action(`SC_UP, 1'b1, 1'b0, mask_up, "up make");
		// Arrow codes without E0 belong to no cabinet key
		key_action(`SC_LEFT, 1'b0, 1'b0, 8'h00, "bare left code");
		key_action(`SC_UP, 1'b0, 1'b1, 8'h00, "bare up break");
		key_action(`SC_UP, 1'b1, 1'b1, mask_up, "up break");
		for (int r = 0; r < 2; r++) begin
			drive_stick(8'h00, 8'h00, r[0], "rotation select");
			key_action(`SC_UP, 1'b1, 1'b0, mask_up, "arrow up make");
			key_action(`SC_UP, 1'b1, 1'b1, mask_up, "arrow up break");
			key_action(`SC_DOWN, 1'b1, 1'b0, mask_down, "arrow down make");
			key_action(`SC_DOWN, 1'b1, 1'b1, mask_down, "arrow down break");
			key_action(`SC_LEFT, 1'b1, 1'b0, mask_left, "arrow left make");
			key_action(`SC_LEFT, 1'b1, 1'b1, mask_left, "arrow left break");
			key_action(`SC_RIGHT, 1'b1, 1'b0, mask_right, "arrow right make");
			key_action(`SC_RIGHT, 1'b1, 1'b1, mask_right, "arrow right break");
		end
		key_action(`SC_LEFT, 1'b1, 1'b0, mask_left, "left key held");
		drive_stick(8'h01, 8'h00, 1'b0, "joy0 right with left key");
		drive_stick(8'h01, 8'h00, 1'b1, "rotated joy0 right with left key");
		drive_stick(8'h00, 8'h08, 1'b1, "rotated joy1 up with left key");
		drive_stick(8'h00, 8'h00, 1'b0, "joysticks idle");
		key_action(`SC_LEFT, 1'b1, 1'b1, mask_left, "left key released");
		key_action(`SC_FIRE, 1'b0, 1'b0, mask_fire, "space make");
		drive_stick(8'h10, 8'h00, 1'b0, "joy0 fire with space");
		key_action(`SC_FIRE, 1'b0, 1'b1, mask_fire, "space break with joy0 fire");
		drive_stick(8'h00, 8'h10, 1'b0, "joy1 fire");
		drive_stick(8'h00, 8'h00, 1'b0, "fire idle");
	endtask

	task automatic bad_frame_recovery();
		send_frame(`SC_COIN, 1'b1);
		wait_controls("coin with bad parity");
		key_action(`SC_COIN, 1'b0, 1'b0, mask_coin, "coin after bad frame");
		// A lost break prefix turns the next code into a make
		send_frame(`SC_BREAK, 1'b1);
		key_action(`SC_COIN, 1'b0, 1'b0, mask_coin, "coin after bad break prefix");
		key_action(`SC_COIN, 1'b0, 1'b1, mask_coin, "coin break after recovery");
	endtask

	task automatic video_pipeline();
		vga_video_t  exp_q [$];
		vga_video_t  exp;
		vga_video_t  head;
		core_video_t px;
		scanline_e   mode;
		logic        par;
		logic        prev_hs;
		int          p;
		par     = 1'b0;
		prev_hs = 1'b0;
		// Four frames of 46 pixels use one scanline mode each and three flush pixels follow
		for (int c = 0; c < 4 * 46 + 3; c++) begin
			mode = scanline_e'((c / 46) % 4);
			p    = c % 46;
			px   = '0;
			if (c >= 4 * 46)
				px = '0;
			else if (p < 2) begin
				px.vs     = 1'b1;
				px.vblank = 1'b1;
			end else if ((p - 2) % 11 < 3) begin
				px.hs     = ((p - 2) % 11 < 2);
				px.hblank = 1'b1;
			end else begin
				px.r      = 3'(random_bits(3));
				px.g      = 3'(random_bits(3));
				px.b      = 3'(random_bits(3));
				px.hblank = (random_bits(3) == 32'd0);
			end
			if (px.vs)
				par = 1'b0;
			else if (px.hs && !prev_hs)
				par = ~par;
			prev_hs = px.hs;
			exp     = '0;
			exp.hs  = px.hs;
			exp.vs  = px.vs;
			if (!px.hblank && !px.vblank) begin
				exp.r = scanline_level(px.r, par ? mode : SL_NONE);
				exp.g = scanline_level(px.g, par ? mode : SL_NONE);
				exp.b = scanline_level(px.b, par ? mode : SL_NONE);
			end
			@(negedge clk_sys);
			if (exp_q.size() == 3) begin
				head = exp_q.pop_front();
				check_value(32'(vga), 32'(head), "vga pixel three cycles after core pixel");
			end
			ce_pix     = 1'b1;
			scanlines  = mode;
			core_video = px;
			exp_q.push_back(exp);
		end
	endtask

	task automatic audio_density();
		logic [`PLAT_AUDIO_W-1:0] s;
		int                       ones;
		apply_reset();
		for (int k = 0; k < 6; k++) begin
			s = (k == 0) ? 10'd0 : (k == 1) ? 10'd1023 : 10'(random_bits(10));
			@(negedge clk_sys);
			sample = s;
			ones   = 0;
			// The first cycle still carries the previous sample
			for (int i = 0; i < 1025; i++) begin
				@(negedge clk_sys);
				if (i > 0)
					ones += audio;
			end
			check_value(32'(ones), 32'(s), "audio ones over 1024 cycles");
		end
	endtask

	initial begin
		rst        = 1'b0;
		ps2_clk    = 1'b1;
		ps2_data   = 1'b1;
		joy0       = 8'h00;
		joy1       = 8'h00;
		rotate     = 1'b0;
		scanlines  = SL_NONE;
		ce_pix     = 1'b0;
		core_video = '0;
		sample     = '0;
		kb_model   = '0;
		lfsr_state = 32'h7cdc_f300;
		apply_reset();
		coin_start_keys();
		arrows_and_rotation();
		bad_frame_recovery();
		video_pipeline();
		audio_density();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
ps2_pkg.sv
platform_pkg.sv
ps2_receiver.sv
kbd_decoder.sv
control_mapper.sv
video_front.sv
color_channel.sv
vga_out.sv
sigma_delta_dac.sv
arcade_platform.sv
tb_arcade_platform.sv
